//--- list.f
rtl/timer_pkg.sv
rtl/timer_csr.sv
rtl/timer_rtc_sync.sv
rtl/timer_prescaler.sv
rtl/timer_mtime.sv
rtl/timer_top.sv
tests/tb_timer_top.sv

//--- Makefile
# Verilator build and run of the machine timer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_timer_top
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_timer_top.sv
// Self-checking testbench for the machine timer
// Clock and RTC generation, data-memory port tasks, register model,
// register, error, counting, interrupt and RTC source checks
`timescale 1ns/1ps

module tb_timer_top;

    localparam int unsigned SEED           = 32'h3b85;
    localparam int          CLK_PERIOD     = 100;
    localparam int          RTC_PERIOD     = 730;
    localparam int          DRIVE_DELAY    = 10;
    // About twice the length of all tests together
    localparam int unsigned TIMEOUT_CYCLES = 40000;

    logic                             clk;
    logic                             rtc_clk;
    logic                             rst_n;
    logic                             dmem_req;
    timer_pkg::mem_cmd_e              dmem_cmd;
    timer_pkg::mem_width_e            dmem_width;
    logic [timer_pkg::ADDR_WIDTH-1:0] dmem_addr;
    logic [timer_pkg::DATA_WIDTH-1:0] dmem_wdata;
    logic                             dmem_req_ack;
    timer_pkg::mem_resp_e             dmem_resp;
    logic [timer_pkg::DATA_WIDTH-1:0] dmem_rdata;
    logic [63:0]                      timer_val;
    logic                             timer_irq;

    // Register model with mtime valid only while disabled
    logic [1:0]                       m_ctrl;
    logic [timer_pkg::DIV_WIDTH-1:0]  m_div;
    logic [63:0]                      m_cmp;
    logic [63:0]                      m_mtime;

    int unsigned cycle_cnt = 0;
    int unsigned rtc_edges = 0;

    timer_top UUT (
        .clk          (clk),
        .rtc_clk      (rtc_clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_req_ack (dmem_req_ack),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .timer_val    (timer_val),
        .timer_irq    (timer_irq)
    );

    // --------------------------------------------------
    // Clocks, edge counter and timeout
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // Unrelated to clk
    initial begin
        rtc_clk = 1'b0;
        forever begin
            #(RTC_PERIOD / 2);
            rtc_clk = ~rtc_clk;
        end
    end

    always @(posedge rtc_clk) begin
        rtc_edges <= rtc_edges + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clk cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic compare_value(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
        if (exp_val !== act_val) begin
            $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp_val, act_val);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Returns at the drive point after n rising edges
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DELAY);
        end
    endtask

    task automatic bus_access(input timer_pkg::mem_cmd_e cmd,
                              input timer_pkg::mem_width_e width,
                              input logic [timer_pkg::ADDR_WIDTH-1:0] addr,
                              input logic [31:0] wdata,
                              output timer_pkg::mem_resp_e resp,
                              output logic [31:0] rdata);
        dmem_req   = 1'b1;
        dmem_cmd   = cmd;
        dmem_width = width;
        dmem_addr  = addr;
        dmem_wdata = wdata;
        // Acknowledge one cycle after the request
        wait_cycles(1);
        compare_value("dmem_req_ack", 64'(1'b1), 64'(dmem_req_ack));
        compare_value("dmem_resp", 64'(timer_pkg::MEM_RESP_NOTRDY), 64'(dmem_resp));
        dmem_req = 1'b0;
        // Response one cycle after the acknowledge
        wait_cycles(1);
        compare_value("dmem_req_ack", 64'(1'b0), 64'(dmem_req_ack));
        resp  = dmem_resp;
        rdata = dmem_rdata;
        if (cmd == timer_pkg::MEM_CMD_WR || resp != timer_pkg::MEM_RESP_RDY_OK) begin
            compare_value("dmem_rdata", 64'h0, 64'(dmem_rdata));
        end
    endtask

    task automatic write_reg(input timer_pkg::timer_reg_e addr, input logic [31:0] data);
        timer_pkg::mem_resp_e resp;
        logic [31:0]          rdata;
        bus_access(timer_pkg::MEM_CMD_WR, timer_pkg::MEM_WIDTH_WORD, addr, data, resp, rdata);
        compare_value("dmem_resp", 64'(timer_pkg::MEM_RESP_RDY_OK), 64'(resp));
        case (addr)
            timer_pkg::REG_CONTROL:    m_ctrl          = data[1:0];
            timer_pkg::REG_DIVIDER:    m_div           = data[timer_pkg::DIV_WIDTH-1:0];
            timer_pkg::REG_MTIMELO:    m_mtime[31:0]   = data;
            timer_pkg::REG_MTIMEHI:    m_mtime[63:32]  = data;
            timer_pkg::REG_MTIMECMPLO: m_cmp[31:0]     = data;
            timer_pkg::REG_MTIMECMPHI: m_cmp[63:32]    = data;
            default: begin
            end
        endcase
        // Register updates on the edge after the response
        wait_cycles(1);
        compare_value("dmem_resp", 64'(timer_pkg::MEM_RESP_NOTRDY), 64'(dmem_resp));
    endtask

    task automatic read_reg(input timer_pkg::timer_reg_e addr, output logic [31:0] data);
        timer_pkg::mem_resp_e resp;
        bus_access(timer_pkg::MEM_CMD_RD, timer_pkg::MEM_WIDTH_WORD, addr, 32'h0, resp, data);
        compare_value("dmem_resp", 64'(timer_pkg::MEM_RESP_RDY_OK), 64'(resp));
    endtask

    // Read back every register against the model
    task automatic verify_regs(input logic with_mtime);
        logic [31:0] rd;
        read_reg(timer_pkg::REG_CONTROL, rd);
        compare_value("control", 64'(m_ctrl), 64'(rd));
        read_reg(timer_pkg::REG_DIVIDER, rd);
        compare_value("divider", 64'(m_div), 64'(rd));
        read_reg(timer_pkg::REG_MTIMECMPLO, rd);
        compare_value("mtimecmp_lo", 64'(m_cmp[31:0]), 64'(rd));
        read_reg(timer_pkg::REG_MTIMECMPHI, rd);
        compare_value("mtimecmp_hi", 64'(m_cmp[63:32]), 64'(rd));
        if (with_mtime) begin
            read_reg(timer_pkg::REG_MTIMELO, rd);
            compare_value("mtime_lo", 64'(m_mtime[31:0]), 64'(rd));
            read_reg(timer_pkg::REG_MTIMEHI, rd);
            compare_value("mtime_hi", 64'(m_mtime[63:32]), 64'(rd));
            compare_value("timer_val", m_mtime, timer_val);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0]           rnd;
        logic [31:0]           rdata;
        logic [31:0]           prev_hi;
        logic [31:0]           cur_hi;
        logic [63:0]           v0;
        logic [63:0]           v1;
        logic [63:0]           delta;
        logic [63:0]           lo_b;
        logic [63:0]           hi_b;
        logic [63:0]           d;
        logic [63:0]           edges;
        logic [timer_pkg::ADDR_WIDTH-1:0] addr;
        timer_pkg::mem_cmd_e   cmd;
        timer_pkg::mem_width_e width;
        timer_pkg::mem_resp_e  resp;
        int                    n;
        int                    kind;
        int                    incs;
        int                    hit_wait;
        int unsigned           e0;
        logic                  hit_seen;
        logic                  irq_ok;

        void'($urandom(SEED));
        rst_n      = 1'b0;
        dmem_req   = 1'b0;
        dmem_cmd   = timer_pkg::MEM_CMD_RD;
        dmem_width = timer_pkg::MEM_WIDTH_WORD;
        dmem_addr  = '0;
        dmem_wdata = '0;
        m_ctrl     = 2'b01;
        m_div      = '0;
        m_cmp      = '0;
        m_mtime    = '0;

        repeat (10) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        wait_cycles(2);

        // Reset values
        $display("Test 1: reset values and bus timing");
        compare_value("timer_irq", 64'(1'b0), 64'(timer_irq));
        verify_regs(1'b0);

        // Register round trip with the timer stopped
        $display("Test 2: register round trip");
        rnd = $urandom;
        write_reg(timer_pkg::REG_CONTROL, rnd & 32'hFFFF_FFFE);
        write_reg(timer_pkg::REG_DIVIDER, $urandom);
        write_reg(timer_pkg::REG_MTIMELO, $urandom);
        write_reg(timer_pkg::REG_MTIMEHI, $urandom);
        write_reg(timer_pkg::REG_MTIMECMPLO, $urandom);
        write_reg(timer_pkg::REG_MTIMECMPHI, $urandom);
        verify_regs(1'b1);
        wait_cycles(20);
        compare_value("timer_val", m_mtime, timer_val);

        // Misaligned, narrow and out-of-map accesses
        $display("Test 3: illegal accesses");
        for (int i = 0; i < 24; i++) begin
            kind  = int'($urandom % 3);
            width = timer_pkg::MEM_WIDTH_WORD;
            if ($urandom % 2 == 0) begin
                cmd = timer_pkg::MEM_CMD_RD;
            end else begin
                cmd = timer_pkg::MEM_CMD_WR;
            end
            if (kind == 0) begin
                addr = 5'(($urandom % 6) * 4 + 1 + ($urandom % 3));
            end else if (kind == 1) begin
                addr = 5'(($urandom % 6) * 4);
                if ($urandom % 2 == 0) begin
                    width = timer_pkg::MEM_WIDTH_BYTE;
                end else begin
                    width = timer_pkg::MEM_WIDTH_HWORD;
                end
            end else begin
                addr = ($urandom % 2 == 0) ? 5'h18 : 5'h1C;
            end
            bus_access(cmd, width, addr, $urandom, resp, rdata);
            compare_value("dmem_resp", 64'(timer_pkg::MEM_RESP_RDY_ER), 64'(resp));
        end
        wait_cycles(1);
        verify_regs(1'b1);

        // Core clock rate for a few dividers
        $display("Test 4: core clock counting and carry");
        for (int r = 0; r < 3; r++) begin
            d = 64'($urandom % 8);
            write_reg(timer_pkg::REG_DIVIDER, d[31:0]);
            if (r == 0) begin
                write_reg(timer_pkg::REG_CONTROL, 32'h1);
            end
            wait_cycles(4);
            n  = 200 + int'($urandom % 300);
            v0 = timer_val;
            wait_cycles(n);
            v1    = timer_val;
            delta = v1 - v0;
            lo_b  = 64'(n) / (d + 1) - 1;
            hi_b  = (64'(n) + d) / (d + 1) + 1;
            $display("Divider %0d over %0d cycles, growth %0d", d, n, delta);
            compare_value("mtime_growth_in_range", 64'(1'b1),
                          64'(delta >= lo_b && delta <= hi_b));
        end

        // Carry from the low half into the high half
        write_reg(timer_pkg::REG_CONTROL, 32'h0);
        write_reg(timer_pkg::REG_DIVIDER, 32'h0);
        write_reg(timer_pkg::REG_MTIMEHI, $urandom);
        write_reg(timer_pkg::REG_MTIMELO, 32'hFFFF_FFF0);
        compare_value("timer_val", m_mtime, timer_val);
        prev_hi = timer_val[63:32];
        write_reg(timer_pkg::REG_CONTROL, 32'h1);
        incs = 0;
        repeat (40) begin
            wait_cycles(1);
            cur_hi = timer_val[63:32];
            if (cur_hi != prev_hi) begin
                incs++;
                compare_value("mtime_hi", 64'(prev_hi + 32'd1), 64'(cur_hi));
            end
            prev_hi = cur_hi;
        end
        compare_value("mtime_hi_increments", 64'(1), 64'(incs));

        // Interrupt on compare
        $display("Test 5: timer interrupt");
        write_reg(timer_pkg::REG_CONTROL, 32'h0);
        wait_cycles(2);
        v0 = timer_val + 64'(1 + ($urandom % 49));
        write_reg(timer_pkg::REG_MTIMECMPHI, v0[63:32]);
        write_reg(timer_pkg::REG_MTIMECMPLO, v0[31:0]);
        compare_value("timer_irq", 64'(1'b0), 64'(timer_irq));
        write_reg(timer_pkg::REG_CONTROL, 32'h1);
        hit_seen = 1'b0;
        irq_ok   = 1'b0;
        hit_wait = 0;
        for (int i = 0; i < 100 && !irq_ok; i++) begin
            wait_cycles(1);
            if (!hit_seen) begin
                if (timer_val >= m_cmp) begin
                    hit_seen = 1'b1;
                end else begin
                    compare_value("timer_irq", 64'(1'b0), 64'(timer_irq));
                end
            end
            if (hit_seen) begin
                if (timer_irq) begin
                    irq_ok = 1'b1;
                end else begin
                    // Allowed latency after the count reaches compare
                    compare_value("irq_within_2_cycles", 64'(1'b1), 64'(hit_wait < 2));
                    hit_wait++;
                end
            end
        end
        compare_value("timer_irq", 64'(1'b1), 64'(irq_ok));
        repeat (20) begin
            wait_cycles(1);
            compare_value("timer_irq", 64'(1'b1), 64'(timer_irq));
        end
        // Compare moved far ahead clears it
        v1 = timer_val;
        write_reg(timer_pkg::REG_MTIMECMPHI, v1[63:32] + 32'd1);
        write_reg(timer_pkg::REG_MTIMECMPLO, v1[31:0]);
        repeat (10) begin
            compare_value("timer_irq", 64'(1'b0), 64'(timer_irq));
            wait_cycles(1);
        end
        verify_regs(1'b0);

        // RTC as tick source
        $display("Test 6: RTC source");
        write_reg(timer_pkg::REG_DIVIDER, 32'h0);
        write_reg(timer_pkg::REG_CONTROL, 32'h3);
        wait_cycles(20);
        n  = 15000 + int'($urandom % 1000);
        e0 = rtc_edges;
        v0 = timer_val;
        wait_cycles(n);
        v1    = timer_val;
        edges = 64'(rtc_edges - e0);
        delta = v1 - v0;
        $display("RTC window of %0d cycles, %0d edges, growth %0d", n, edges, delta);
        compare_value("rtc_growth_in_range", 64'(1'b1),
                      64'(delta + 2 >= edges && delta <= edges + 2));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- rtl/timer_top.sv
// Machine timer top level
// Register front end, RTC synchronizer, prescaler and time counter
`timescale 1ns/1ps

module timer_top (
    input  logic                             clk,
    input  logic                             rtc_clk,
    input  logic                             rst_n,
    // Data-memory request port
    input  logic                             dmem_req,
    input  timer_pkg::mem_cmd_e              dmem_cmd,
    input  timer_pkg::mem_width_e            dmem_width,
    input  logic [timer_pkg::ADDR_WIDTH-1:0] dmem_addr,
    input  logic [timer_pkg::DATA_WIDTH-1:0] dmem_wdata,
    output logic                             dmem_req_ack,
    output timer_pkg::mem_resp_e             dmem_resp,
    output logic [timer_pkg::DATA_WIDTH-1:0] dmem_rdata,
    // Time value and interrupt to the core
    output logic [63:0]                      timer_val,
    output logic                             timer_irq
);

    logic                             timer_en;
    logic                             clksrc_rtc;
    logic [timer_pkg::DIV_WIDTH-1:0]  timer_div;
    logic                             div_we;
    logic                             mtimelo_we;
    logic                             mtimehi_we;
    logic                             cmplo_we;
    logic                             cmphi_we;
    logic [timer_pkg::DATA_WIDTH-1:0] wdata_q;
    logic                             rtc_pulse;
    logic                             tick;
    logic [63:0]                      mtime;
    logic [63:0]                      mtimecmp;

    // --------------------------------------------------
    // Bus front end
    // --------------------------------------------------
    // Control strobe is consumed inside the front end
    timer_csr u_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_req_ack (dmem_req_ack),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .mtime        (mtime),
        .mtimecmp     (mtimecmp),
        .timer_en     (timer_en),
        .clksrc_rtc   (clksrc_rtc),
        .timer_div    (timer_div),
        .ctrl_we      (),
        .div_we       (div_we),
        .mtimelo_we   (mtimelo_we),
        .mtimehi_we   (mtimehi_we),
        .cmplo_we     (cmplo_we),
        .cmphi_we     (cmphi_we),
        .wdata_q      (wdata_q)
    );

    // --------------------------------------------------
    // Time base
    // --------------------------------------------------
    timer_rtc_sync u_rtc_sync (
        .clk        (clk),
        .rtc_clk    (rtc_clk),
        .rst_n      (rst_n),
        .clksrc_rtc (clksrc_rtc),
        .rtc_pulse  (rtc_pulse)
    );

    timer_prescaler u_prescaler (
        .clk        (clk),
        .rst_n      (rst_n),
        .timer_en   (timer_en),
        .clksrc_rtc (clksrc_rtc),
        .rtc_pulse  (rtc_pulse),
        .timer_div  (timer_div),
        .div_we     (div_we),
        .wdata_q    (wdata_q),
        .tick       (tick)
    );

    // Counter, compare and interrupt
    timer_mtime u_mtime (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .mtimelo_we (mtimelo_we),
        .mtimehi_we (mtimehi_we),
        .cmplo_we   (cmplo_we),
        .cmphi_we   (cmphi_we),
        .wdata_q    (wdata_q),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .timer_irq  (timer_irq)
    );

    assign timer_val = mtime;

endmodule

//--- rtl/timer_mtime.sv
// Machine time counter with compare
// 64-bit mtime built from two 32-bit adders with a registered carry,
// 64-bit mtimecmp written by halves, sticky level interrupt
`timescale 1ns/1ps

module timer_mtime (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             tick,
    // Write strobes from the front end
    input  logic                             mtimelo_we,
    input  logic                             mtimehi_we,
    input  logic                             cmplo_we,
    input  logic                             cmphi_we,
    input  logic [timer_pkg::DATA_WIDTH-1:0] wdata_q,
    output logic [63:0]                      mtime,
    output logic [63:0]                      mtimecmp,
    output logic                             timer_irq
);

    logic [31:0] lo_nxt;
    logic [31:0] hi_nxt;
    logic        mtime_upd;
    // Low half is all ones, next tick carries
    logic        lo_ones_q;
    logic [63:0] cmp_nxt;
    logic        cmp_we;
    logic        cmp_armed_q;
    logic        cmp_hit;

    // --------------------------------------------------
    // Time counter
    // --------------------------------------------------
    always_comb begin
        lo_nxt = mtime[31:0];
        hi_nxt = mtime[63:32];
        if (tick) begin
            // Tick wins over a software write in the same cycle
            lo_nxt = mtime[31:0] + 32'd1;
            if (lo_ones_q) begin
                hi_nxt = mtime[63:32] + 32'd1;
            end
        end else begin
            if (mtimelo_we) begin
                lo_nxt = wdata_q;
            end
            if (mtimehi_we) begin
                hi_nxt = wdata_q;
            end
        end
    end

    assign mtime_upd = tick | mtimelo_we | mtimehi_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime     <= '0;
            lo_ones_q <= 1'b0;
        end else if (mtime_upd) begin
            mtime     <= {hi_nxt, lo_nxt};
            // Carry for the next increment, kept off the adder path
            lo_ones_q <= &lo_nxt;
        end
    end

    // --------------------------------------------------
    // Compare register
    // --------------------------------------------------
    assign cmp_we = cmplo_we | cmphi_we;

    always_comb begin
        cmp_nxt = mtimecmp;
        if (cmplo_we) begin
            cmp_nxt[31:0] = wdata_q;
        end
        if (cmphi_we) begin
            cmp_nxt[63:32] = wdata_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp    <= '0;
            cmp_armed_q <= 1'b0;
        end else if (cmp_we) begin
            mtimecmp    <= cmp_nxt;
            cmp_armed_q <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Interrupt
    // --------------------------------------------------
    // Compare stays idle until first programmed
    // During a write the new value is the one compared
    assign cmp_hit = (cmp_armed_q | cmp_we) & (mtime >= cmp_nxt);

    // Sticky once set; only a compare write can clear it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else if (!timer_irq || cmp_we) begin
            timer_irq <= cmp_hit;
        end
    end

endmodule

//--- rtl/timer_prescaler.sv
// Time-base prescaler
// Source select between core clock and RTC pulses, enable gating
// and a reloading down-counter that issues time ticks
`timescale 1ns/1ps

module timer_prescaler (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             timer_en,
    input  logic                             clksrc_rtc,
    input  logic                             rtc_pulse,
    input  logic [timer_pkg::DIV_WIDTH-1:0]  timer_div,
    input  logic                             div_we,
    input  logic [timer_pkg::DATA_WIDTH-1:0] wdata_q,
    output logic                             tick
);

    logic                            src_en;
    logic                            cnt_zero;
    logic [timer_pkg::DIV_WIDTH-1:0] cnt_q;

    // --------------------------------------------------
    // Source select
    // --------------------------------------------------
    // Every core cycle, or one cycle per rtc edge
    assign src_en   = timer_en & (clksrc_rtc ? rtc_pulse : 1'b1);
    assign cnt_zero = (cnt_q == '0);

    // --------------------------------------------------
    // Down-counter
    // --------------------------------------------------
    // Divider write restarts the period with the new value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (div_we) begin
            cnt_q <= wdata_q[timer_pkg::DIV_WIDTH-1:0];
        end else if (src_en) begin
            if (cnt_zero) begin
                cnt_q <= timer_div;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // One tick per divider+1 enabled source cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick <= 1'b0;
        end else begin
            tick <= src_en & cnt_zero;
        end
    end

endmodule

//--- rtl/timer_rtc_sync.sv
// RTC edge synchronizer
// Toggle flop in the rtc_clk domain, three-flop chain in clk,
// single-cycle pulse per rtc_clk rising edge
`timescale 1ns/1ps

module timer_rtc_sync (
    input  logic clk,
    input  logic rtc_clk,
    input  logic rst_n,
    input  logic clksrc_rtc,
    output logic rtc_pulse
);

    logic       rtc_tgl;
    // [0] metastable capture, [2:1] edge detect
    logic [2:0] sync_q;

    // --------------------------------------------------
    // rtc_clk domain
    // --------------------------------------------------
    // Flips on every rtc edge while the RTC source is selected
    always_ff @(posedge rtc_clk or negedge rst_n) begin
        if (!rst_n) begin
            rtc_tgl <= 1'b0;
        end else if (clksrc_rtc) begin
            rtc_tgl <= ~rtc_tgl;
        end
    end

    // --------------------------------------------------
    // clk domain
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else if (clksrc_rtc) begin
            sync_q <= {sync_q[1:0], rtc_tgl};
        end
    end

    // Any change of the synchronized flag is one rtc edge
    assign rtc_pulse = sync_q[2] ^ sync_q[1];

endmodule

//--- rtl/timer_csr.sv
// Register front end of the machine timer
// Data-memory port handshake, access checks, control and divider registers,
// write strobes and read data
`timescale 1ns/1ps

module timer_csr (
    input  logic                             clk,
    input  logic                             rst_n,
    // Data-memory request port
    input  logic                             dmem_req,
    input  timer_pkg::mem_cmd_e              dmem_cmd,
    input  timer_pkg::mem_width_e            dmem_width,
    input  logic [timer_pkg::ADDR_WIDTH-1:0] dmem_addr,
    input  logic [timer_pkg::DATA_WIDTH-1:0] dmem_wdata,
    output logic                             dmem_req_ack,
    output timer_pkg::mem_resp_e             dmem_resp,
    output logic [timer_pkg::DATA_WIDTH-1:0] dmem_rdata,
    // Counter state for reads
    input  logic [63:0]                      mtime,
    input  logic [63:0]                      mtimecmp,
    // Control fields
    output logic                             timer_en,
    output logic                             clksrc_rtc,
    output logic [timer_pkg::DIV_WIDTH-1:0]  timer_div,
    // Write strobes, high in the response cycle
    output logic                             ctrl_we,
    output logic                             div_we,
    output logic                             mtimelo_we,
    output logic                             mtimehi_we,
    output logic                             cmplo_we,
    output logic                             cmphi_we,
    output logic [timer_pkg::DATA_WIDTH-1:0] wdata_q
);

    logic                             accept;
    logic                             legal;
    logic                             legal_q;
    logic                             wr_q;
    timer_pkg::mem_cmd_e              cmd_q;
    logic [timer_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [timer_pkg::DATA_WIDTH-1:0] rd_word;

    // --------------------------------------------------
    // Request stage
    // --------------------------------------------------
    // No acceptance in the acknowledge cycle
    assign accept = dmem_req & ~dmem_req_ack;

    // Word only, aligned, inside the register map
    assign legal = (dmem_width == timer_pkg::MEM_WIDTH_WORD)
                 & (dmem_addr[1:0] == 2'b00)
                 & (dmem_addr <= timer_pkg::REG_MTIMECMPHI);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_req_ack <= 1'b0;
            legal_q      <= 1'b0;
        end else begin
            dmem_req_ack <= accept;
            legal_q      <= accept & legal;
        end
    end

    // Access payload, stable until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q   <= dmem_cmd;
            addr_q  <= dmem_addr;
            wdata_q <= dmem_wdata;
        end
    end

    // --------------------------------------------------
    // Response stage
    // --------------------------------------------------
    always_comb begin
        rd_word = '0;
        case (addr_q)
            timer_pkg::REG_CONTROL: begin
                rd_word[timer_pkg::CTRL_EN_BIT]     = timer_en;
                rd_word[timer_pkg::CTRL_CLKSRC_BIT] = clksrc_rtc;
            end
            timer_pkg::REG_DIVIDER:    rd_word[timer_pkg::DIV_WIDTH-1:0] = timer_div;
            timer_pkg::REG_MTIMELO:    rd_word = mtime[31:0];
            timer_pkg::REG_MTIMEHI:    rd_word = mtime[63:32];
            timer_pkg::REG_MTIMECMPLO: rd_word = mtimecmp[31:0];
            timer_pkg::REG_MTIMECMPHI: rd_word = mtimecmp[63:32];
            default:                   rd_word = '0;
        endcase
    end

    // One response cycle after the acknowledge, idle otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_resp  <= timer_pkg::MEM_RESP_NOTRDY;
            dmem_rdata <= '0;
            wr_q       <= 1'b0;
        end else begin
            dmem_resp  <= timer_pkg::MEM_RESP_NOTRDY;
            dmem_rdata <= '0;
            wr_q       <= 1'b0;
            if (dmem_req_ack) begin
                if (!legal_q) begin
                    dmem_resp <= timer_pkg::MEM_RESP_RDY_ER;
                end else if (cmd_q == timer_pkg::MEM_CMD_RD) begin
                    dmem_resp  <= timer_pkg::MEM_RESP_RDY_OK;
                    dmem_rdata <= rd_word;
                end else begin
                    dmem_resp <= timer_pkg::MEM_RESP_RDY_OK;
                    wr_q      <= 1'b1;
                end
            end
        end
    end

    // Write decode, one strobe per legal write
    always_comb begin
        ctrl_we    = 1'b0;
        div_we     = 1'b0;
        mtimelo_we = 1'b0;
        mtimehi_we = 1'b0;
        cmplo_we   = 1'b0;
        cmphi_we   = 1'b0;
        if (wr_q) begin
            case (addr_q)
                timer_pkg::REG_CONTROL:    ctrl_we    = 1'b1;
                timer_pkg::REG_DIVIDER:    div_we     = 1'b1;
                timer_pkg::REG_MTIMELO:    mtimelo_we = 1'b1;
                timer_pkg::REG_MTIMEHI:    mtimehi_we = 1'b1;
                timer_pkg::REG_MTIMECMPLO: cmplo_we   = 1'b1;
                timer_pkg::REG_MTIMECMPHI: cmphi_we   = 1'b1;
                default: begin
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Control and divider registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_en   <= timer_pkg::CTRL_EN_RST;
            clksrc_rtc <= timer_pkg::CTRL_CLKSRC_RST;
            timer_div  <= '0;
        end else begin
            if (ctrl_we) begin
                timer_en   <= wdata_q[timer_pkg::CTRL_EN_BIT];
                clksrc_rtc <= wdata_q[timer_pkg::CTRL_CLKSRC_BIT];
            end
            if (div_we) begin
                timer_div <= wdata_q[timer_pkg::DIV_WIDTH-1:0];
            end
        end
    end

endmodule

//--- rtl/timer_pkg.sv
// Shared definitions for the memory-mapped machine timer
// Widths, data-memory port encodings, register map and control fields
package timer_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned ADDR_WIDTH = 5;
    localparam int unsigned DATA_WIDTH = 32;
    // Divider register and prescaler count
    localparam int unsigned DIV_WIDTH  = 10;

    // --------------------------------------------------
    // Data-memory port encodings
    // --------------------------------------------------
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // --------------------------------------------------
    // Register map, byte offsets
    // --------------------------------------------------
    typedef enum logic [ADDR_WIDTH-1:0] {
        REG_CONTROL    = 5'h00,
        REG_DIVIDER    = 5'h04,
        REG_MTIMELO    = 5'h08,
        REG_MTIMEHI    = 5'h0C,
        REG_MTIMECMPLO = 5'h10,
        REG_MTIMECMPHI = 5'h14
    } timer_reg_e;

    // Control register fields and their reset values
    localparam int unsigned CTRL_EN_BIT     = 0;
    localparam int unsigned CTRL_CLKSRC_BIT = 1;
    localparam logic        CTRL_EN_RST     = 1'b1;
    // Core clock selected out of reset
    localparam logic        CTRL_CLKSRC_RST = 1'b0;

endpackage
